// ==== verilog/branchPredictor_defs.svh ====
`ifndef BRANCH_PREDICTOR_DEFS_SVH
`define BRANCH_PREDICTOR_DEFS_SVH

// program counter width and the byte offset dropped before indexing
`define PC_WIDTH        32
`define BYTE_OFFSET     2

// local history bits per branch, also the pattern table index width
`define HIST_WIDTH      4

// table index widths, both taken from pc bits just above the byte offset
`define BHT_INDEX_WIDTH 4
`define BTB_INDEX_WIDTH 4

// derived table sizes and tag widths
`define PHT_ENTRIES     (1 << `HIST_WIDTH)
`define BHT_ENTRIES     (1 << `BHT_INDEX_WIDTH)
`define BTB_ENTRIES     (1 << `BTB_INDEX_WIDTH)
`define BHT_TAG_WIDTH   (`PC_WIDTH - `BHT_INDEX_WIDTH - `BYTE_OFFSET)
`define BTB_TAG_WIDTH   (`PC_WIDTH - `BTB_INDEX_WIDTH - `BYTE_OFFSET)

`endif

// ==== verilog/branchPredictorPkg.sv ====
`include "branchPredictor_defs.svh"

package branchPredictorPkg;

    // 2-bit saturating counter, taken when the upper bit is set
    typedef enum logic [1:0] {
        stronglyNotTaken = 2'd0,
        weaklyNotTaken   = 2'd1,
        weaklyTaken      = 2'd2,
        stronglyTaken    = 2'd3
    } counterState_e;

    // per-branch local history, newest outcome in bit 0
    typedef logic [`HIST_WIDTH-1:0] history_t;

    // lookup request from fetch, sent every cycle
    typedef struct packed {
        logic                 valid;
        logic [`PC_WIDTH-1:0] pc;
    } fetchReq_t;

    // resolved branch from execute, valid for one cycle per branch
    typedef struct packed {
        logic                 valid;
        logic [`PC_WIDTH-1:0] pc;
        logic                 taken;   // actual outcome
        logic [`PC_WIDTH-1:0] target;  // resolved target address
    } resolve_t;

    // registered prediction, one cycle after the request
    typedef struct packed {
        logic                 valid;   // echo of request valid
        logic                 hit;     // known to both tag tables, counter valid
        logic                 taken;
        logic [`PC_WIDTH-1:0] target;  // stored target or pc + 4
    } prediction_t;

endpackage

// ==== verilog/branchHistoryTable.sv ====
`include "branchPredictor_defs.svh"

module branchHistoryTable (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [`PC_WIDTH-1:0]         lookupPc,
    input  branchPredictorPkg::resolve_t resolve,
    output branchPredictorPkg::history_t lookupHistory,
    output branchPredictorPkg::history_t updateHistory,
    output logic                         lookupHit
);

    // per-entry storage, only the valid bits are control state
    logic [`BHT_TAG_WIDTH-1:0]    tagArray     [`BHT_ENTRIES];
    branchPredictorPkg::history_t historyArray [`BHT_ENTRIES];
    logic [`BHT_ENTRIES-1:0]      validBits;

    // fetch side read port
    logic [`BHT_INDEX_WIDTH-1:0]  lookupIndex;
    logic [`BHT_TAG_WIDTH-1:0]    lookupTag;

    // execute side read port
    logic [`BHT_INDEX_WIDTH-1:0]  updateIndex;
    logic [`BHT_TAG_WIDTH-1:0]    updateTag;
    logic                         updateHit;

    // history written back on a valid resolve
    branchPredictorPkg::history_t trainedHistory;

    assign lookupIndex = lookupPc[`BHT_INDEX_WIDTH+`BYTE_OFFSET-1:`BYTE_OFFSET];
    assign lookupTag   = lookupPc[`PC_WIDTH-1:`BHT_INDEX_WIDTH+`BYTE_OFFSET];

    assign updateIndex = resolve.pc[`BHT_INDEX_WIDTH+`BYTE_OFFSET-1:`BYTE_OFFSET];
    assign updateTag   = resolve.pc[`PC_WIDTH-1:`BHT_INDEX_WIDTH+`BYTE_OFFSET];

    // lookup hit needs a valid entry with a matching tag
    assign lookupHit     = validBits[lookupIndex] && (tagArray[lookupIndex] == lookupTag);
    assign lookupHistory = lookupHit ? historyArray[lookupIndex] : '0;

    // pre-shift history of the resolving branch, zero on a tag miss
    assign updateHit     = validBits[updateIndex] && (tagArray[updateIndex] == updateTag);
    assign updateHistory = updateHit ? historyArray[updateIndex] : '0;

    always_comb begin
        if (updateHit) begin
            // known branch, shift the outcome in at the bottom
            trainedHistory = {updateHistory[`HIST_WIDTH-2:0], resolve.taken};
        end else begin
            // new branch, history starts from this outcome alone
            trainedHistory = {{(`HIST_WIDTH-1){1'b0}}, resolve.taken};
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            validBits <= '0;
        end else if (resolve.valid) begin
            validBits[updateIndex] <= 1'b1;  // hit or allocate, entry is valid after
        end
    end

    always_ff @(posedge clk) begin
        if (resolve.valid) begin
            tagArray[updateIndex]     <= updateTag;  // same tag on a hit, new owner on a miss
            historyArray[updateIndex] <= trainedHistory;
        end
    end

endmodule

// ==== verilog/patternHistoryTable.sv ====
`include "branchPredictor_defs.svh"

module patternHistoryTable (
    input  logic                         clk,
    input  logic                         reset,
    input  branchPredictorPkg::history_t lookupIndex,
    input  branchPredictorPkg::history_t updateIndex,
    input  logic                         updateValid,
    input  logic                         updateTaken,
    output logic                         phtTaken,
    output logic                         phtValid
);

    // one counter and one valid bit per history pattern
    branchPredictorPkg::counterState_e counterArray [`PHT_ENTRIES];
    logic [`PHT_ENTRIES-1:0]           validBits;

    branchPredictorPkg::counterState_e lookupState;
    branchPredictorPkg::counterState_e updateState;
    branchPredictorPkg::counterState_e nextState;

    // direction read, upper half of the counter range predicts taken
    assign lookupState = counterArray[lookupIndex];
    assign phtTaken    = (lookupState == branchPredictorPkg::weaklyTaken) ||
                         (lookupState == branchPredictorPkg::stronglyTaken);
    assign phtValid    = validBits[lookupIndex];

    assign updateState = counterArray[updateIndex];

    always_comb begin
        nextState = updateState;
        if (!validBits[updateIndex]) begin
            // first fill lands in the weak state of the outcome
            if (updateTaken) begin
                nextState = branchPredictorPkg::weaklyTaken;
            end else begin
                nextState = branchPredictorPkg::weaklyNotTaken;
            end
        end else begin
            case (updateState)
                branchPredictorPkg::stronglyNotTaken: begin
                    if (updateTaken) begin
                        nextState = branchPredictorPkg::weaklyNotTaken;
                    end  // saturates on not taken
                end
                branchPredictorPkg::weaklyNotTaken: begin
                    if (updateTaken) begin
                        nextState = branchPredictorPkg::weaklyTaken;
                    end else begin
                        nextState = branchPredictorPkg::stronglyNotTaken;
                    end
                end
                branchPredictorPkg::weaklyTaken: begin
                    if (updateTaken) begin
                        nextState = branchPredictorPkg::stronglyTaken;
                    end else begin
                        nextState = branchPredictorPkg::weaklyNotTaken;
                    end
                end
                branchPredictorPkg::stronglyTaken: begin
                    if (!updateTaken) begin
                        nextState = branchPredictorPkg::weaklyTaken;
                    end  // saturates on taken
                end
                default: nextState = updateState;
            endcase
        end
    end

    // counters come out of reset weakly taken, but invalid
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            validBits <= '0;
            for (int i = 0; i < `PHT_ENTRIES; i++) begin
                counterArray[i] <= branchPredictorPkg::weaklyTaken;
            end
        end else if (updateValid) begin
            validBits[updateIndex]    <= 1'b1;
            counterArray[updateIndex] <= nextState;
        end
    end

endmodule

// ==== verilog/branchTargetBuffer.sv ====
`include "branchPredictor_defs.svh"

module branchTargetBuffer (
    input  logic                            clk,
    input  logic                            reset,
    input  branchPredictorPkg::fetchReq_t   fetchReq,
    input  logic                            historyHit,
    input  logic                            phtTaken,
    input  logic                            phtValid,
    input  branchPredictorPkg::resolve_t    resolve,
    output branchPredictorPkg::prediction_t prediction
);

    localparam logic [`PC_WIDTH-1:0] instrBytes = 4;  // fall-through step

    // target storage, filled only by taken branches
    logic [`BTB_TAG_WIDTH-1:0]   tagArray    [`BTB_ENTRIES];
    logic [`PC_WIDTH-1:0]        targetArray [`BTB_ENTRIES];
    logic [`BTB_ENTRIES-1:0]     validBits;

    logic [`BTB_INDEX_WIDTH-1:0] lookupIndex;
    logic [`BTB_TAG_WIDTH-1:0]   lookupTag;
    logic [`BTB_INDEX_WIDTH-1:0] updateIndex;
    logic [`BTB_TAG_WIDTH-1:0]   updateTag;
    logic                        writeEnable;

    // combined lookup result before the output register
    logic                        btbHit;
    logic                        hitNext;
    logic                        takenNext;
    logic [`PC_WIDTH-1:0]        fallThrough;
    logic [`PC_WIDTH-1:0]        targetNext;

    // output register stage
    logic                        validReg;
    logic                        hitReg;
    logic                        takenReg;
    logic [`PC_WIDTH-1:0]        targetReg;

    assign lookupIndex = fetchReq.pc[`BTB_INDEX_WIDTH+`BYTE_OFFSET-1:`BYTE_OFFSET];
    assign lookupTag   = fetchReq.pc[`PC_WIDTH-1:`BTB_INDEX_WIDTH+`BYTE_OFFSET];
    assign updateIndex = resolve.pc[`BTB_INDEX_WIDTH+`BYTE_OFFSET-1:`BYTE_OFFSET];
    assign updateTag   = resolve.pc[`PC_WIDTH-1:`BTB_INDEX_WIDTH+`BYTE_OFFSET];
    assign writeEnable = resolve.valid && resolve.taken;  // not-taken leaves the entry alone

    assign btbHit = validBits[lookupIndex] && (tagArray[lookupIndex] == lookupTag);

    // a hit needs history tag, valid counter and target tag
    assign hitNext     = historyHit && phtValid && btbHit;
    assign takenNext   = hitNext && phtTaken;
    assign fallThrough = fetchReq.pc + instrBytes;
    assign targetNext  = hitNext ? targetArray[lookupIndex] : fallThrough;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            validBits <= '0;
        end else if (writeEnable) begin
            validBits[updateIndex] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            tagArray[updateIndex]    <= updateTag;
            targetArray[updateIndex] <= resolve.target;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            validReg <= 1'b0;
            hitReg   <= 1'b0;
            takenReg <= 1'b0;
        end else begin
            validReg <= fetchReq.valid;  // follows the request one cycle later
            hitReg   <= hitNext;
            takenReg <= takenNext;
        end
    end

    always_ff @(posedge clk) begin
        targetReg <= targetNext;
    end

    assign prediction = '{valid: validReg, hit: hitReg, taken: takenReg, target: targetReg};

endmodule

// ==== verilog/branchPredictor.sv ====
module branchPredictor (
    input  logic                            clk,
    input  logic                            reset,
    input  branchPredictorPkg::fetchReq_t   fetchReq,
    input  branchPredictorPkg::resolve_t    resolve,
    output branchPredictorPkg::prediction_t prediction
);

    // history table results for the fetch pc and the resolving pc
    branchPredictorPkg::history_t lookupHistory;
    branchPredictorPkg::history_t updateHistory;
    logic                         lookupHit;

    // pattern table direction for the fetch history
    logic                         phtTaken;
    logic                         phtValid;

    branchHistoryTable bht (
        .clk           (clk),
        .reset         (reset),
        .lookupPc      (fetchReq.pc),
        .resolve       (resolve),
        .lookupHistory (lookupHistory),
        .updateHistory (updateHistory),
        .lookupHit     (lookupHit)
    );

    // indexed by history only, the pc is not hashed in
    patternHistoryTable pht (
        .clk         (clk),
        .reset       (reset),
        .lookupIndex (lookupHistory),
        .updateIndex (updateHistory),
        .updateValid (resolve.valid),
        .updateTaken (resolve.taken),
        .phtTaken    (phtTaken),
        .phtValid    (phtValid)
    );

    // final combine and the single register stage
    branchTargetBuffer btb (
        .clk        (clk),
        .reset      (reset),
        .fetchReq   (fetchReq),
        .historyHit (lookupHit),
        .phtTaken   (phtTaken),
        .phtValid   (phtValid),
        .resolve    (resolve),
        .prediction (prediction)
    );

endmodule

// ==== tests/branchPredictorTb.sv ====
`include "branchPredictor_defs.svh"

module branchPredictorTb;

    localparam int resetCycles    = 8;
    localparam int directedCycles = 40;
    localparam int randomCycles   = 300;
    localparam int cycleLimit     = 2 * (directedCycles + randomCycles) + resetCycles;

    // pcA and pcB share an index but not a tag
    localparam logic [`PC_WIDTH-1:0] pcA     = 32'h0000_1008;
    localparam logic [`PC_WIDTH-1:0] pcB     = 32'h0000_2008;
    localparam logic [`PC_WIDTH-1:0] pcC     = 32'h0000_100C;
    localparam logic [`PC_WIDTH-1:0] pcD     = 32'h0000_4010;
    localparam logic [`PC_WIDTH-1:0] targetA = 32'h0000_3000;
    localparam logic [`PC_WIDTH-1:0] targetB = 32'h0000_5A40;

    logic                            clk;
    logic                            reset;
    branchPredictorPkg::fetchReq_t   fetchReq;
    branchPredictorPkg::resolve_t    resolve;
    branchPredictorPkg::prediction_t prediction;

    // reference copies of the three tables
    logic                          bhtValidRef  [`BHT_ENTRIES];
    logic [`BHT_TAG_WIDTH-1:0]     bhtTagRef    [`BHT_ENTRIES];
    logic [`HIST_WIDTH-1:0]        bhtHistRef   [`BHT_ENTRIES];
    logic                          phtValidRef  [`PHT_ENTRIES];
    logic [1:0]                    phtCtrRef    [`PHT_ENTRIES];
    logic                          btbValidRef  [`BTB_ENTRIES];
    logic [`BTB_TAG_WIDTH-1:0]     btbTagRef    [`BTB_ENTRIES];
    logic [`PC_WIDTH-1:0]          btbTargetRef [`BTB_ENTRIES];

    logic [`PC_WIDTH-1:0]            pcSet [4];
    branchPredictorPkg::prediction_t expectedPred;
    logic                            expectReady = 1'b0;
    int                              seed = 32'h195c05dc;
    int                              rnd;
    int                              cycleCount = 0;

    branchPredictor uut (
        .clk        (clk),
        .reset      (reset),
        .fetchReq   (fetchReq),
        .resolve    (resolve),
        .prediction (prediction)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic branchPredictorPkg::prediction_t predictRef(
        input branchPredictorPkg::fetchReq_t req
    );
        logic [`BHT_INDEX_WIDTH-1:0]     hIdx;
        logic [`BTB_INDEX_WIDTH-1:0]     tIdx;
        logic                            histHit;
        logic                            btbHit;
        logic [`HIST_WIDTH-1:0]          hist;
        branchPredictorPkg::prediction_t p;
        hIdx    = req.pc[`BHT_INDEX_WIDTH+`BYTE_OFFSET-1:`BYTE_OFFSET];
        tIdx    = req.pc[`BTB_INDEX_WIDTH+`BYTE_OFFSET-1:`BYTE_OFFSET];
        histHit = bhtValidRef[hIdx] &&
                  (bhtTagRef[hIdx] == req.pc[`PC_WIDTH-1:`BHT_INDEX_WIDTH+`BYTE_OFFSET]);
        btbHit  = btbValidRef[tIdx] &&
                  (btbTagRef[tIdx] == req.pc[`PC_WIDTH-1:`BTB_INDEX_WIDTH+`BYTE_OFFSET]);
        hist    = histHit ? bhtHistRef[hIdx] : '0;  // miss reads counter 0
        p.valid  = req.valid;
        p.hit    = histHit && phtValidRef[hist] && btbHit;
        p.taken  = p.hit && (phtCtrRef[hist] >= 2'd2);
        p.target = p.hit ? btbTargetRef[tIdx] : req.pc + 32'd4;
        return p;
    endfunction

    task automatic trainRef(input branchPredictorPkg::resolve_t res);
        logic [`BHT_INDEX_WIDTH-1:0] hIdx;
        logic [`BTB_INDEX_WIDTH-1:0] tIdx;
        logic [`BHT_TAG_WIDTH-1:0]   hTag;
        logic                        histHit;
        logic [`HIST_WIDTH-1:0]      oldHist;
        hIdx    = res.pc[`BHT_INDEX_WIDTH+`BYTE_OFFSET-1:`BYTE_OFFSET];
        tIdx    = res.pc[`BTB_INDEX_WIDTH+`BYTE_OFFSET-1:`BYTE_OFFSET];
        hTag    = res.pc[`PC_WIDTH-1:`BHT_INDEX_WIDTH+`BYTE_OFFSET];
        histHit = bhtValidRef[hIdx] && (bhtTagRef[hIdx] == hTag);
        oldHist = histHit ? bhtHistRef[hIdx] : '0;
        if (res.valid) begin
            if (!phtValidRef[oldHist]) begin
                phtCtrRef[oldHist]   = res.taken ? 2'd2 : 2'd1;  // first fill lands weak
                phtValidRef[oldHist] = 1'b1;
            end else if (res.taken && phtCtrRef[oldHist] != 2'd3) begin
                phtCtrRef[oldHist] = phtCtrRef[oldHist] + 2'd1;
            end else if (!res.taken && phtCtrRef[oldHist] != 2'd0) begin
                phtCtrRef[oldHist] = phtCtrRef[oldHist] - 2'd1;
            end
            bhtHistRef[hIdx]  = histHit ? {oldHist[`HIST_WIDTH-2:0], res.taken}
                                        : {{(`HIST_WIDTH-1){1'b0}}, res.taken};
            bhtTagRef[hIdx]   = hTag;
            bhtValidRef[hIdx] = 1'b1;
            if (res.taken) begin
                btbTagRef[tIdx]    = res.pc[`PC_WIDTH-1:`BTB_INDEX_WIDTH+`BYTE_OFFSET];
                btbTargetRef[tIdx] = res.target;
                btbValidRef[tIdx]  = 1'b1;
            end
        end
    endtask

    task automatic checkValue(input string fieldName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] time %0t: %s expected %h, actual %h",
                     $time, fieldName, expected, actual);
            $display("test failed");
            $fatal(1, "prediction mismatch");
        end
    endtask

    // one cycle of stimulus applied on the falling edge
    task automatic driveCycle(input logic reqValid, input logic [31:0] reqPc,
                              input logic resValid, input logic [31:0] resPc,
                              input logic resTaken, input logic [31:0] resTarget);
        @(negedge clk);
        fetchReq.valid = reqValid;
        fetchReq.pc    = reqPc;
        resolve.valid  = resValid;
        resolve.pc     = resPc;
        resolve.taken  = resTaken;
        resolve.target = resTarget;
    endtask

    // expected result taken from the state before this edge's training
    always @(posedge clk) begin
        if (!reset) begin
            expectedPred = predictRef(fetchReq);
            trainRef(resolve);
            expectReady  = 1'b1;
        end
    end

    always @(negedge clk) begin
        if (expectReady) begin
            checkValue("prediction.valid", expectedPred.valid, prediction.valid);
            checkValue("prediction.hit", expectedPred.hit, prediction.hit);
            checkValue("prediction.taken", expectedPred.taken, prediction.taken);
            checkValue("prediction.target", expectedPred.target, prediction.target);
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            cycleCount++;
            if (cycleCount >= cycleLimit) begin
                $display("simulation timed out after %0d cycles without finishing", cycleCount);
                $display("test failed");
                $fatal(1, "timeout");
            end
        end
    end

    initial begin
        fetchReq = '0;
        resolve  = '0;
        reset    = 1'b1;
        pcSet    = '{pcA, pcB, pcC, pcD};
        for (int i = 0; i < `BHT_ENTRIES; i++) begin
            bhtValidRef[i] = 1'b0;
        end
        for (int i = 0; i < `PHT_ENTRIES; i++) begin
            phtValidRef[i] = 1'b0;
            phtCtrRef[i]   = 2'd2;  // weakly taken out of reset
        end
        for (int i = 0; i < `BTB_ENTRIES; i++) begin
            btbValidRef[i] = 1'b0;
        end
        repeat (resetCycles) @(negedge clk);
        reset = 1'b0;

        // every lookup falls through on empty tables
        driveCycle(1'b1, pcA, 1'b0, '0, 1'b0, '0);
        driveCycle(1'b1, pcB, 1'b0, '0, 1'b0, '0);
        driveCycle(1'b0, pcC, 1'b0, '0, 1'b0, '0);
        driveCycle(1'b1, pcD, 1'b0, '0, 1'b0, '0);
        driveCycle(1'b1, 32'hFFFF_FFFC, 1'b0, '0, 1'b0, '0);

        // taken run with a lookup of the same pc in the update cycle
        repeat (6) driveCycle(1'b1, pcA, 1'b1, pcA, 1'b1, targetA);
        repeat (2) driveCycle(1'b1, pcA, 1'b0, '0, 1'b0, '0);

        // not-taken run saturates and taken climbs back
        repeat (8) driveCycle(1'b1, pcA, 1'b1, pcA, 1'b0, targetA);
        repeat (6) driveCycle(1'b1, pcA, 1'b1, pcA, 1'b1, targetA);

        // pcB aliases pcA and takes over both entries
        driveCycle(1'b1, pcB, 1'b0, '0, 1'b0, '0);
        driveCycle(1'b1, pcB, 1'b1, pcB, 1'b1, targetB);
        driveCycle(1'b1, pcA, 1'b0, '0, 1'b0, '0);
        driveCycle(1'b1, pcB, 1'b0, '0, 1'b0, '0);

        // valid low on either side
        repeat (2) driveCycle(1'b0, pcB, 1'b0, pcB, 1'b0, targetA);
        driveCycle(1'b1, pcB, 1'b0, pcA, 1'b1, targetA);
        driveCycle(1'b1, pcA, 1'b0, pcB, 1'b0, targetA);
        driveCycle(1'b1, pcB, 1'b0, '0, 1'b0, '0);

        for (int i = 0; i < randomCycles; i++) begin
            rnd = $random(seed);
            driveCycle(rnd[0] | rnd[1], pcSet[rnd[5:4]], rnd[2], pcSet[rnd[7:6]], rnd[3],
                       {14'h0, rnd[23:8], 2'b00});
        end

        repeat (2) driveCycle(1'b0, '0, 1'b0, '0, 1'b0, '0);
        @(posedge clk);
        $display("test passed");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+verilog
verilog/branchPredictorPkg.sv
verilog/branchHistoryTable.sv
verilog/patternHistoryTable.sv
verilog/branchTargetBuffer.sv
verilog/branchPredictor.sv
tests/branchPredictorTb.sv
